//--- project.f
src/riscv_isa_pkg.sv
src/id_ctrl_pkg.sv
src/id_decoder.sv
src/id_operand_mux.sv
src/id_ex_fsm.sv
src/id_stage.sv
sim/id_stage_sva.sv
sim/tb_id_stage.sv

//--- Bender.yml
package:
  name: id_stage

sources:
  - src/riscv_isa_pkg.sv
  - src/id_ctrl_pkg.sv
  - src/id_decoder.sv
  - src/id_operand_mux.sv
  - src/id_ex_fsm.sv
  - src/id_stage.sv
  - target: simulation
    files:
      - sim/id_stage_sva.sv
      - sim/tb_id_stage.sv

//--- sim/tb_id_stage.sv
/*
 * Testbench for the decode stage: reference decode model, random stimulus
 * per instruction class and a compare process sampling at the falling edge
 */

`timescale 1ns/1ns

module tb_id_stage import riscv_isa_pkg::*; import id_ctrl_pkg::*;;

  localparam int unsigned SEED    = 32'h01af_1644;
  localparam int          TIMEOUT = 16;

  localparam logic [6:0] OPCODES [9] = '{OPC_LUI, OPC_AUIPC, OPC_JAL, OPC_JALR, OPC_BRANCH,
                                         OPC_LOAD, OPC_STORE, OPC_OP_IMM, OPC_OP};

  // Expected decode of one instruction
  typedef struct packed {
    logic        illegal;
    logic [1:0]  cls;
    logic [3:0]  alu_op;
    logic [31:0] op_a;
    logic [31:0] op_b;
    logic [31:0] imm_b;
    logic        we;
    logic [4:0]  waddr;
    logic [4:0]  raddr_a;
    logic [4:0]  raddr_b;
    logic        lsu_we;
    logic [1:0]  lsu_type;
    logic        sign_ext;
  } exp_t;

  logic        clk_i;
  logic        rst_ni;
  logic        instr_valid_i;
  logic [31:0] instr_rdata_i;
  logic [31:0] pc_id_i;
  logic [31:0] rf_rdata_a_i;
  logic [31:0] rf_rdata_b_i;
  logic        branch_decision_i;
  logic        lsu_resp_valid_i;
  logic        id_in_ready_o;
  logic        illegal_insn_o;
  logic [4:0]  rf_raddr_a_o;
  logic [4:0]  rf_raddr_b_o;
  logic [4:0]  rf_waddr_o;
  logic        rf_we_o;
  alu_op_e     alu_operator_o;
  logic [31:0] alu_operand_a_o;
  logic [31:0] alu_operand_b_o;
  logic        pc_set_o;
  logic        lsu_req_o;
  logic        lsu_we_o;
  lsu_type_e   lsu_type_o;
  logic        lsu_sign_ext_o;
  logic [31:0] lsu_wdata_o;

  // Expectations for the current cycle, written by the driver
  exp_t        cur;
  logic [31:0] cur_pc;
  logic [31:0] cur_rb;
  logic        exp_ready;
  logic        exp_req;
  logic        exp_pcset;
  logic        exp_we;
  logic        exp_illegal;
  logic [31:0] exp_op_a;
  logic [31:0] exp_op_b;

  int          n_checks;
  int          n_errors;
  int          n_insns;
  int          n_tests;
  int          err_base;
  int          insn_base;
  logic [31:0] ins;

  id_stage dut0 (.*);

  initial begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  //////////////////////////////
  // Reference model
  //////////////////////////////

  function automatic exp_t ref_decode(input logic [31:0] insn, input logic [31:0] pc,
                                      input logic [31:0] ra, input logic [31:0] rb);
    exp_t        e;
    logic [2:0]  f3;
    logic [6:0]  f7;
    logic        wr;
    logic [31:0] imm_i;
    logic [31:0] imm_s;
    logic [31:0] imm_u;
    logic [31:0] imm_j;
    f3    = insn[14:12];
    f7    = insn[31:25];
    imm_i = {{20{insn[31]}}, insn[31:20]};
    imm_s = {{20{insn[31]}}, insn[31:25], insn[11:7]};
    imm_u = {insn[31:12], 12'h000};
    imm_j = {{12{insn[31]}}, insn[19:12], insn[20], insn[30:21], 1'b0};
    e         = '0;
    e.imm_b   = {{20{insn[31]}}, insn[7], insn[30:25], insn[11:8], 1'b0};
    e.waddr   = insn[11:7];
    e.raddr_a = insn[19:15];
    e.raddr_b = insn[24:20];
    // Default is rs1 plus the I immediate
    e.cls    = CLS_ALU;
    e.alu_op = ALU_ADD;
    e.op_a   = ra;
    e.op_b   = imm_i;
    wr       = 1'b0;
    case (insn[6:0])
      OPC_LUI: begin
        e.op_a = '0;
        e.op_b = imm_u;
        wr     = 1'b1;
      end
      OPC_AUIPC: begin
        e.op_a = pc;
        e.op_b = imm_u;
        wr     = 1'b1;
      end
      OPC_JAL: begin
        e.cls  = CLS_JUMP;
        e.op_a = pc;
        e.op_b = imm_j;
        wr     = 1'b1;
      end
      OPC_JALR: begin
        e.cls     = CLS_JUMP;
        wr        = 1'b1;
        e.illegal = (f3 != 3'd0);
      end
      OPC_BRANCH: begin
        e.cls  = CLS_BRANCH;
        e.op_b = rb;
        case (f3)
          3'd0:    e.alu_op = ALU_EQ;
          3'd1:    e.alu_op = ALU_NE;
          3'd4:    e.alu_op = ALU_LT;
          3'd5:    e.alu_op = ALU_GE;
          3'd6:    e.alu_op = ALU_LTU;
          3'd7:    e.alu_op = ALU_GEU;
          default: e.illegal = 1'b1;
        endcase
      end
      OPC_LOAD, OPC_STORE: begin
        e.cls      = CLS_MEM;
        e.lsu_type = (f3[1:0] == 2'd0) ? BYTE : (f3[1:0] == 2'd1) ? HALF : WORD;
        if (insn[6:0] == OPC_LOAD) begin
          // Unsigned variants exist for bytes and halves only
          wr         = 1'b1;
          e.sign_ext = ~f3[2];
          e.illegal  = (f3 == 3'd3) || (f3 >= 3'd6);
        end else begin
          e.op_b    = imm_s;
          e.lsu_we  = 1'b1;
          e.illegal = (f3 > 3'd2);
        end
      end
      OPC_OP, OPC_OP_IMM: begin
        wr = 1'b1;
        if (insn[6:0] == OPC_OP) begin
          e.op_b = rb;
        end
        case (f3)
          3'd0:    e.alu_op = ALU_ADD;
          3'd1:    e.alu_op = ALU_SLL;
          3'd2:    e.alu_op = ALU_SLT;
          3'd3:    e.alu_op = ALU_SLTU;
          3'd4:    e.alu_op = ALU_XOR;
          3'd5:    e.alu_op = (f7 == F7_ALT) ? ALU_SRA : ALU_SRL;
          3'd6:    e.alu_op = ALU_OR;
          default: e.alu_op = ALU_AND;
        endcase
        if (insn[6:0] == OPC_OP) begin
          if (f3 == 3'd0 && f7 == F7_ALT) e.alu_op = ALU_SUB;
          e.illegal = !(f7 == 7'd0 || (f7 == F7_ALT && (f3 == 3'd0 || f3 == 3'd5)));
        end else if (f3 == 3'd1) begin
          e.illegal = (f7 != 7'd0);
        end else if (f3 == 3'd5) begin
          e.illegal = !(f7 == 7'd0 || f7 == F7_ALT);
        end
      end
      default: e.illegal = 1'b1;
    endcase
    // Illegal encodings retire at once with no side effects
    if (e.illegal) begin
      e.cls    = CLS_ALU;
      e.lsu_we = 1'b0;
    end
    e.we = wr && !e.illegal && (e.waddr != 5'd0);
    return e;
  endfunction

  //////////////////////////////
  // Stimulus generators
  //////////////////////////////

  // Random legal encoding of one opcode, funct7 steered toward legal values
  function automatic logic [31:0] gen_legal(input logic [6:0] opc);
    logic [31:0] w;
    exp_t        e;
    w = '0;
    for (int i = 0; i < 64; i++) begin
      w      = $urandom;
      w[6:0] = opc;
      if (opc == OPC_OP || opc == OPC_OP_IMM) begin
        w[31:25] = $urandom_range(1, 0) ? F7_ALT : 7'h00;
      end
      e = ref_decode(w, '0, '0, '0);
      if (!e.illegal) break;
    end
    return w;
  endfunction

  // Unknown opcodes and bad funct fields of known opcodes
  function automatic logic [31:0] gen_illegal();
    logic [31:0] w;
    exp_t        e;
    w = '0;
    for (int i = 0; i < 64; i++) begin
      w = $urandom;
      if ($urandom_range(1, 0)) w[6:0] = OPCODES[$urandom_range(8, 0)];
      e = ref_decode(w, '0, '0, '0);
      if (e.illegal) break;
    end
    return w;
  endfunction

  function automatic logic [6:0] pick_alu_opcode();
    int unsigned sel;
    sel = $urandom_range(3, 0);
    return (sel == 0) ? OPC_OP : (sel == 1) ? OPC_OP_IMM : (sel == 2) ? OPC_LUI : OPC_AUIPC;
  endfunction

  //////////////////////////////
  // Compare process
  //////////////////////////////

  task automatic check_field(input string name, input logic [31:0] got,
                             input logic [31:0] want);
    n_checks++;
    if (got !== want) begin
      n_errors++;
      $display("mismatch %s: got %h, expected %h at %0t", name, got, want, $time);
    end
  endtask

  // Inputs settle 1 ns after the rising edge, so the falling edge is stable
  always @(negedge clk_i) begin
    if (rst_ni) begin
      check_field("id_in_ready_o", id_in_ready_o, exp_ready);
      check_field("lsu_req_o", lsu_req_o, exp_req);
      check_field("pc_set_o", pc_set_o, exp_pcset);
      check_field("rf_we_o", rf_we_o, exp_we);
      check_field("illegal_insn_o", illegal_insn_o, exp_illegal);
      if (instr_valid_i) begin
        check_field("lsu_we_o", lsu_we_o, cur.lsu_we);
        check_field("rf_raddr_a_o", rf_raddr_a_o, cur.raddr_a);
        check_field("rf_raddr_b_o", rf_raddr_b_o, cur.raddr_b);
      end
      if (instr_valid_i && !cur.illegal) begin
        check_field("alu_operator_o", alu_operator_o, cur.alu_op);
        check_field("alu_operand_a_o", alu_operand_a_o, exp_op_a);
        check_field("alu_operand_b_o", alu_operand_b_o, exp_op_b);
        check_field("rf_waddr_o", rf_waddr_o, cur.waddr);
        if (cur.cls == CLS_MEM) begin
          check_field("lsu_type_o", lsu_type_o, cur.lsu_type);
          if (cur.lsu_we) begin
            check_field("lsu_wdata_o", lsu_wdata_o, cur_rb);
          end else begin
            check_field("lsu_sign_ext_o", lsu_sign_ext_o, cur.sign_ext);
          end
        end
      end
    end
  end

  //////////////////////////////
  // Driver tasks
  //////////////////////////////

  task automatic clear_expect();
    exp_ready   = 1'b0;
    exp_req     = 1'b0;
    exp_pcset   = 1'b0;
    exp_we      = 1'b0;
    exp_illegal = 1'b0;
  endtask

  task automatic stop_on_timeout(input string what);
    $display("timeout: no %s within %0d cycles at %0t", what, TIMEOUT, $time);
    $display("sim failed");
    $finish;
  endtask

  // Expected outputs for cycle cyc of the current instruction
  task automatic drive_cycle(input int cyc, input logic taken, input int delay);
    clear_expect();
    exp_illegal       = cur.illegal;
    exp_op_a          = cur.op_a;
    exp_op_b          = cur.op_b;
    lsu_resp_valid_i  = 1'b0;
    branch_decision_i = (cur.cls == CLS_BRANCH) ? taken : 1'($urandom_range(1, 0));
    case (cur.cls)
      CLS_MEM: begin
        // A response in the request cycle is ignored
        if (cyc == 0) begin
          exp_req          = 1'b1;
          lsu_resp_valid_i = $urandom_range(1, 0);
        end else if (cyc == delay) begin
          lsu_resp_valid_i = 1'b1;
          exp_ready        = 1'b1;
          exp_we           = cur.we;
        end
      end
      CLS_BRANCH: begin
        if (cyc == 0) begin
          exp_ready = ~taken;
        end else begin
          exp_ready = 1'b1;
          exp_pcset = 1'b1;
          exp_op_a  = cur_pc;
          exp_op_b  = cur.imm_b;
        end
      end
      CLS_JUMP: begin
        if (cyc == 0) begin
          exp_pcset = 1'b1;
        end else begin
          exp_ready = 1'b1;
          exp_we    = cur.we;
          exp_op_a  = cur_pc;
          exp_op_b  = 32'd4;
        end
      end
      default: begin
        exp_ready = 1'b1;
        exp_we    = cur.we;
      end
    endcase
  endtask

  // Present one instruction and hold it until the stage accepts it
  task automatic run_insn(input logic [31:0] insn, input logic taken, input int delay);
    int   cyc;
    logic retired;
    cur_pc        = $urandom & 32'hffff_fffc;
    cur_rb        = $urandom;
    rf_rdata_a_i  = $urandom;
    rf_rdata_b_i  = cur_rb;
    pc_id_i       = cur_pc;
    instr_rdata_i = insn;
    instr_valid_i = 1'b1;
    cur           = ref_decode(insn, cur_pc, rf_rdata_a_i, cur_rb);
    cyc           = 0;
    retired       = 1'b0;
    while (!retired && cyc <= TIMEOUT) begin
      drive_cycle(cyc, taken, delay);
      @(negedge clk_i);
      retired = id_in_ready_o;
      @(posedge clk_i);
      #1;
      cyc++;
    end
    if (retired) begin
      n_insns++;
    end else begin
      stop_on_timeout("id_in_ready_o");
    end
  endtask

  // Valid low with random noise on the other inputs
  task automatic idle(input int n);
    instr_valid_i = 1'b0;
    clear_expect();
    repeat (n) begin
      instr_rdata_i     = $urandom;
      branch_decision_i = $urandom_range(1, 0);
      lsu_resp_valid_i  = $urandom_range(1, 0);
      @(posedge clk_i);
      #1;
    end
  endtask

  task automatic apply_reset();
    instr_valid_i = 1'b0;
    clear_expect();
    rst_ni = 1'b0;
    repeat (2) @(posedge clk_i);
    #1;
    rst_ni = 1'b1;
  endtask

  task automatic end_test(input string name);
    n_tests++;
    $display("test %s: %0d instructions, %0d errors", name, n_insns - insn_base,
             n_errors - err_base);
    err_base  = n_errors;
    insn_base = n_insns;
  endtask

  //////////////////////////////
  // Test sequence
  //////////////////////////////

  initial begin
    rst_ni            = 1'b0;
    instr_valid_i     = 1'b0;
    instr_rdata_i     = '0;
    pc_id_i           = '0;
    rf_rdata_a_i      = '0;
    rf_rdata_b_i      = '0;
    branch_decision_i = 1'b0;
    lsu_resp_valid_i  = 1'b0;
    cur               = '0;
    n_checks          = 0;
    n_errors          = 0;
    n_insns           = 0;
    n_tests           = 0;
    err_base          = 0;
    insn_base         = 0;
    void'($urandom(SEED));
    clear_expect();
    apply_reset();
    idle(3);

    // Register and immediate ALU ops, some writing x0
    repeat (40) begin
      ins = gen_legal(pick_alu_opcode());
      if ($urandom_range(3, 0) == 0) ins[11:7] = 5'd0;
      run_insn(ins, 1'b0, 0);
    end
    idle(2);
    end_test("alu");

    // Loads and stores with 1 to 4 cycles of response latency
    repeat (30) begin
      ins = gen_legal($urandom_range(1, 0) ? OPC_LOAD : OPC_STORE);
      run_insn(ins, 1'b0, $urandom_range(4, 1));
    end
    idle(2);
    end_test("lsu");

    repeat (30) begin
      run_insn(gen_legal(OPC_BRANCH), $urandom_range(1, 0), 0);
    end
    idle(2);
    end_test("branch");

    repeat (20) begin
      ins = gen_legal($urandom_range(1, 0) ? OPC_JAL : OPC_JALR);
      if ($urandom_range(3, 0) == 0) ins[11:7] = 5'd0;
      run_insn(ins, 1'b0, 0);
    end
    idle(2);
    end_test("jump");

    // Fresh reset, idle outputs, then illegal encodings
    apply_reset();
    idle(4);
    repeat (20) begin
      run_insn(gen_illegal(), $urandom_range(1, 0), 1);
    end
    idle(2);
    end_test("illegal");

    $display("tests %0d, instructions %0d, checks %0d, errors %0d", n_tests, n_insns,
             n_checks, n_errors);
    if (n_errors == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

//--- sim/id_stage_sva.sv
/*
 * Concurrent assertions on the decode stage handshake and control outputs,
 * bound into id_stage
 */

`timescale 1ns/1ns

module id_stage_sva (
  input logic clk_i,
  input logic rst_ni,
  input logic instr_valid_i,
  input logic id_in_ready_i,
  input logic illegal_insn_i,
  input logic lsu_req_i,
  input logic pc_set_i,
  input logic rf_we_i
);

  // One request per memory instruction, the retire cycle never requests
  a_lsu_req_single: assert property (@(posedge clk_i) disable iff (!rst_ni)
    lsu_req_i |=> !lsu_req_i)
    else $error("lsu_req_o high in two consecutive cycles");

  a_pc_set_valid: assert property (@(posedge clk_i) disable iff (!rst_ni)
    pc_set_i |-> instr_valid_i)
    else $error("pc_set_o without a valid instruction");

  // Writes happen only in the retire cycle
  a_we_retire: assert property (@(posedge clk_i) disable iff (!rst_ni)
    rf_we_i |-> id_in_ready_i)
    else $error("rf_we_o outside the retire cycle");

  a_illegal_quiet: assert property (@(posedge clk_i) disable iff (!rst_ni)
    illegal_insn_i |-> id_in_ready_i && !lsu_req_i && !pc_set_i && !rf_we_i)
    else $error("illegal instruction with side effects or stall");

endmodule

bind id_stage id_stage_sva u_sva (
  .clk_i         (clk_i),
  .rst_ni        (rst_ni),
  .instr_valid_i (instr_valid_i),
  .id_in_ready_i (id_in_ready_o),
  .illegal_insn_i(illegal_insn_o),
  .lsu_req_i     (lsu_req_o),
  .pc_set_i      (pc_set_o),
  .rf_we_i       (rf_we_o)
);

//--- src/id_stage.sv
/*
 * Decode stage top: decoder, operand mux and execute FSM
 */

`timescale 1ns/1ns

module id_stage import riscv_isa_pkg::*; import id_ctrl_pkg::*; (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  // Fetch side
  input  logic                  instr_valid_i,
  input  logic [XLEN-1:0]       instr_rdata_i,
  input  logic [XLEN-1:0]       pc_id_i,
  output logic                  id_in_ready_o,
  output logic                  illegal_insn_o,
  // Register file
  output logic [REG_ADDR_W-1:0] rf_raddr_a_o,
  output logic [REG_ADDR_W-1:0] rf_raddr_b_o,
  input  logic [XLEN-1:0]       rf_rdata_a_i,
  input  logic [XLEN-1:0]       rf_rdata_b_i,
  output logic [REG_ADDR_W-1:0] rf_waddr_o,
  output logic                  rf_we_o,
  // EX stage
  output alu_op_e               alu_operator_o,
  output logic [XLEN-1:0]       alu_operand_a_o,
  output logic [XLEN-1:0]       alu_operand_b_o,
  input  logic                  branch_decision_i,
  output logic                  pc_set_o,
  // LSU
  output logic                  lsu_req_o,
  output logic                  lsu_we_o,
  output lsu_type_e             lsu_type_o,
  output logic                  lsu_sign_ext_o,
  output logic [XLEN-1:0]       lsu_wdata_o,
  input  logic                  lsu_resp_valid_i
);

  logic         dec_illegal;
  instr_class_e dec_class;
  op_a_sel_e    op_a_sel;
  op_b_sel_e    op_b_sel;
  imm_b_sel_e   imm_b_sel;
  logic         dec_rf_we;
  logic         first_cycle;

  id_decoder u_decoder (
    .instr_i       (instr_rdata_i),
    .illegal_o     (dec_illegal),
    .class_o       (dec_class),
    .alu_operator_o(alu_operator_o),
    .op_a_sel_o    (op_a_sel),
    .op_b_sel_o    (op_b_sel),
    .imm_b_sel_o   (imm_b_sel),
    .rf_raddr_a_o  (rf_raddr_a_o),
    .rf_raddr_b_o  (rf_raddr_b_o),
    .rf_waddr_o    (rf_waddr_o),
    .rf_we_o       (dec_rf_we),
    .lsu_we_o      (lsu_we_o),
    .lsu_type_o    (lsu_type_o),
    .lsu_sign_ext_o(lsu_sign_ext_o)
  );

  // Operands follow the FSM cycle for branch targets and link addresses
  id_operand_mux u_operand_mux (
    .instr_i      (instr_rdata_i),
    .pc_i         (pc_id_i),
    .rf_rdata_a_i (rf_rdata_a_i),
    .rf_rdata_b_i (rf_rdata_b_i),
    .op_a_sel_i   (op_a_sel),
    .op_b_sel_i   (op_b_sel),
    .imm_b_sel_i  (imm_b_sel),
    .class_i      (dec_class),
    .first_cycle_i(first_cycle),
    .operand_a_o  (alu_operand_a_o),
    .operand_b_o  (alu_operand_b_o),
    .lsu_wdata_o  (lsu_wdata_o)
  );

  id_ex_fsm u_ex_fsm (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .instr_valid_i    (instr_valid_i),
    .illegal_i        (dec_illegal),
    .class_i          (dec_class),
    .dec_rf_we_i      (dec_rf_we),
    .branch_decision_i(branch_decision_i),
    .lsu_resp_valid_i (lsu_resp_valid_i),
    .first_cycle_o    (first_cycle),
    .illegal_o        (illegal_insn_o),
    .lsu_req_o        (lsu_req_o),
    .pc_set_o         (pc_set_o),
    .rf_we_o          (rf_we_o),
    .id_in_ready_o    (id_in_ready_o)
  );

endmodule

//--- src/id_ex_fsm.sv
/*
 * First-cycle/multi-cycle execute FSM with stall, retire,
 * PC-set, LSU request and register write gating
 */

`timescale 1ns/1ns

module id_ex_fsm import id_ctrl_pkg::*; (
  input  logic         clk_i,
  input  logic         rst_ni,
  input  logic         instr_valid_i,
  input  logic         illegal_i,
  input  instr_class_e class_i,
  input  logic         dec_rf_we_i,
  input  logic         branch_decision_i,
  input  logic         lsu_resp_valid_i,
  output logic         first_cycle_o,
  output logic         illegal_o,
  output logic         lsu_req_o,
  output logic         pc_set_o,
  output logic         rf_we_o,
  output logic         id_in_ready_o
);

  typedef enum logic {
    FIRST_CYCLE = 1'b0,
    MULTI_CYCLE = 1'b1
  } id_fsm_e;

  id_fsm_e      fsm_q;
  id_fsm_e      fsm_d;
  logic         branch_taken_q;
  logic         branch_taken_d;
  logic         first_cycle;
  logic         stall;
  logic         done;
  instr_class_e cls;

  // Illegal instructions always go down the single-cycle path
  assign cls         = illegal_i ? CLS_ALU : class_i;
  assign first_cycle = (fsm_q == FIRST_CYCLE);

  //////////////////////////////
  // Next state and stall
  //////////////////////////////

  always_comb begin
    fsm_d          = fsm_q;
    stall          = 1'b0;
    pc_set_o       = 1'b0;
    lsu_req_o      = 1'b0;
    branch_taken_d = 1'b0;

    if (instr_valid_i) begin
      if (first_cycle) begin
        case (cls)
          CLS_MEM: begin
            // Request goes out once, then wait for the response
            lsu_req_o = 1'b1;
            stall     = 1'b1;
            fsm_d     = MULTI_CYCLE;
          end
          CLS_BRANCH: begin
            // Only a taken branch needs the target cycle
            branch_taken_d = branch_decision_i;
            stall          = branch_decision_i;
            fsm_d          = branch_decision_i ? MULTI_CYCLE : FIRST_CYCLE;
          end
          CLS_JUMP: begin
            pc_set_o = 1'b1;
            stall    = 1'b1;
            fsm_d    = MULTI_CYCLE;
          end
          default: fsm_d = FIRST_CYCLE;
        endcase
      end else begin
        // Memory ops hold until the response, others finish now
        stall    = (cls == CLS_MEM) & ~lsu_resp_valid_i;
        pc_set_o = (cls == CLS_BRANCH) & branch_taken_q;
        fsm_d    = stall ? MULTI_CYCLE : FIRST_CYCLE;
      end
    end
  end

  assign done = instr_valid_i & ~stall;

  //////////////////////////////
  // State registers
  //////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      fsm_q          <= FIRST_CYCLE;
      branch_taken_q <= 1'b0;
    end else begin
      fsm_q          <= fsm_d;
      branch_taken_q <= branch_taken_d;
    end
  end

  // Retire cycle gates the handshake and the write
  assign id_in_ready_o = done;
  assign rf_we_o       = done & dec_rf_we_i;
  assign illegal_o     = instr_valid_i & illegal_i;
  assign first_cycle_o = first_cycle;

endmodule

//--- src/id_operand_mux.sv
/*
 * Immediate extraction and ALU operand selection,
 * including the second-cycle overrides for branches and jumps
 */

`timescale 1ns/1ns

module id_operand_mux import riscv_isa_pkg::*; import id_ctrl_pkg::*; (
  input  logic [XLEN-1:0] instr_i,
  input  logic [XLEN-1:0] pc_i,
  input  logic [XLEN-1:0] rf_rdata_a_i,
  input  logic [XLEN-1:0] rf_rdata_b_i,
  input  op_a_sel_e       op_a_sel_i,
  input  op_b_sel_e       op_b_sel_i,
  input  imm_b_sel_e      imm_b_sel_i,
  input  instr_class_e    class_i,
  input  logic            first_cycle_i,
  output logic [XLEN-1:0] operand_a_o,
  output logic [XLEN-1:0] operand_b_o,
  output logic [XLEN-1:0] lsu_wdata_o
);

  logic [XLEN-1:0] imm_i_type;
  logic [XLEN-1:0] imm_s_type;
  logic [XLEN-1:0] imm_b_type;
  logic [XLEN-1:0] imm_u_type;
  logic [XLEN-1:0] imm_j_type;
  logic [XLEN-1:0] imm_b;
  logic            second_branch;
  logic            second_jump;
  op_a_sel_e       op_a_sel;
  op_b_sel_e       op_b_sel;
  imm_b_sel_e      imm_b_sel;

  // Sign-extended immediates, instr[31] is the sign for all of them
  assign imm_i_type = {{20{instr_i[31]}}, instr_i[31:20]};
  assign imm_s_type = {{20{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
  assign imm_b_type = {{19{instr_i[31]}}, instr_i[31], instr_i[7], instr_i[30:25],
                       instr_i[11:8], 1'b0};
  assign imm_u_type = {instr_i[31:12], 12'b0};
  assign imm_j_type = {{11{instr_i[31]}}, instr_i[31], instr_i[19:12], instr_i[20],
                       instr_i[30:21], 1'b0};

  // Second cycle of a branch computes the target, of a jump the link address
  assign second_branch = ~first_cycle_i & (class_i == CLS_BRANCH);
  assign second_jump   = ~first_cycle_i & (class_i == CLS_JUMP);

  assign op_a_sel  = (second_branch | second_jump) ? OP_A_PC : op_a_sel_i;
  assign op_b_sel  = (second_branch | second_jump) ? OP_B_IMM : op_b_sel_i;
  assign imm_b_sel = second_branch ? IMM_B :
                     second_jump   ? IMM_INC : imm_b_sel_i;

  //////////////////////////////
  // Operand muxes
  //////////////////////////////

  always_comb begin
    case (imm_b_sel)
      IMM_I:   imm_b = imm_i_type;
      IMM_S:   imm_b = imm_s_type;
      IMM_B:   imm_b = imm_b_type;
      IMM_U:   imm_b = imm_u_type;
      IMM_J:   imm_b = imm_j_type;
      default: imm_b = INSN_INC;
    endcase
  end

  always_comb begin
    case (op_a_sel)
      OP_A_REG: operand_a_o = rf_rdata_a_i;
      OP_A_PC:  operand_a_o = pc_i;
      default:  operand_a_o = '0;
    endcase
  end

  assign operand_b_o = (op_b_sel == OP_B_IMM) ? imm_b : rf_rdata_b_i;

  // Store data is rs2 unmodified
  assign lsu_wdata_o = rf_rdata_b_i;

endmodule

//--- src/id_decoder.sv
/*
 * Combinational RV32I decoder: instruction class, ALU operator,
 * operand and immediate selects, register addresses, LSU attributes, legality
 */

`timescale 1ns/1ns

module id_decoder import riscv_isa_pkg::*; import id_ctrl_pkg::*; (
  input  logic [XLEN-1:0]       instr_i,
  output logic                  illegal_o,
  output instr_class_e          class_o,
  output alu_op_e               alu_operator_o,
  output op_a_sel_e             op_a_sel_o,
  output op_b_sel_e             op_b_sel_o,
  output imm_b_sel_e            imm_b_sel_o,
  output logic [REG_ADDR_W-1:0] rf_raddr_a_o,
  output logic [REG_ADDR_W-1:0] rf_raddr_b_o,
  output logic [REG_ADDR_W-1:0] rf_waddr_o,
  output logic                  rf_we_o,
  output logic                  lsu_we_o,
  output lsu_type_e             lsu_type_o,
  output logic                  lsu_sign_ext_o
);

  opcode_e                 opcode;
  logic [FUNCT3_W-1:0]     funct3;
  logic [FUNCT7_W-1:0]     funct7;
  logic                    f7_alt;
  logic                    f7_zero;
  logic                    illegal;
  logic                    we;

  //////////////////////////////
  // Field extraction
  //////////////////////////////

  assign opcode  = opcode_e'(instr_i[6:0]);
  assign funct3  = instr_i[F3_LSB +: FUNCT3_W];
  assign funct7  = instr_i[F7_LSB +: FUNCT7_W];
  assign f7_alt  = (funct7 == F7_ALT);
  assign f7_zero = (funct7 == '0);

  // Register addresses come straight from the fixed fields
  assign rf_raddr_a_o = instr_i[RS1_LSB +: REG_ADDR_W];
  assign rf_raddr_b_o = instr_i[RS2_LSB +: REG_ADDR_W];
  assign rf_waddr_o   = instr_i[RD_LSB +: REG_ADDR_W];

  //////////////////////////////
  // Control decode
  //////////////////////////////

  always_comb begin
    // Defaults describe an ALU op on rs1 and the I immediate
    illegal        = 1'b0;
    class_o        = CLS_ALU;
    alu_operator_o = ALU_ADD;
    op_a_sel_o     = OP_A_REG;
    op_b_sel_o     = OP_B_IMM;
    imm_b_sel_o    = IMM_I;
    we             = 1'b0;
    lsu_we_o       = 1'b0;
    lsu_type_o     = WORD;
    lsu_sign_ext_o = 1'b0;

    case (opcode)
      OPC_LUI: begin
        op_a_sel_o  = OP_A_ZERO;
        imm_b_sel_o = IMM_U;
        we          = 1'b1;
      end
      OPC_AUIPC: begin
        op_a_sel_o  = OP_A_PC;
        imm_b_sel_o = IMM_U;
        we          = 1'b1;
      end
      OPC_JAL: begin
        // Target is PC + J immediate, link added by the operand mux
        class_o     = CLS_JUMP;
        op_a_sel_o  = OP_A_PC;
        imm_b_sel_o = IMM_J;
        we          = 1'b1;
      end
      OPC_JALR: begin
        class_o = CLS_JUMP;
        we      = 1'b1;
        illegal = (funct3 != 3'b000);
      end
      OPC_BRANCH: begin
        // Compare rs1 against rs2, B immediate used for the target
        class_o     = CLS_BRANCH;
        op_b_sel_o  = OP_B_REG;
        imm_b_sel_o = IMM_B;
        case (funct3)
          F3_BEQ:  alu_operator_o = ALU_EQ;
          F3_BNE:  alu_operator_o = ALU_NE;
          F3_BLT:  alu_operator_o = ALU_LT;
          F3_BGE:  alu_operator_o = ALU_GE;
          F3_BLTU: alu_operator_o = ALU_LTU;
          F3_BGEU: alu_operator_o = ALU_GEU;
          default: illegal = 1'b1;
        endcase
      end
      OPC_LOAD: begin
        class_o        = CLS_MEM;
        we             = 1'b1;
        lsu_sign_ext_o = ~funct3[2];
        case (funct3)
          F3_B, F3_BU: lsu_type_o = BYTE;
          F3_H, F3_HU: lsu_type_o = HALF;
          F3_W:        lsu_type_o = WORD;
          default:     illegal = 1'b1;
        endcase
      end
      OPC_STORE: begin
        class_o     = CLS_MEM;
        imm_b_sel_o = IMM_S;
        lsu_we_o    = 1'b1;
        case (funct3)
          F3_B:    lsu_type_o = BYTE;
          F3_H:    lsu_type_o = HALF;
          F3_W:    lsu_type_o = WORD;
          default: illegal = 1'b1;
        endcase
      end
      OPC_OP_IMM, OPC_OP: begin
        we = 1'b1;
        if (opcode == OPC_OP) begin
          op_b_sel_o = OP_B_REG;
        end
        case (funct3)
          F3_ADD:  alu_operator_o = (opcode == OPC_OP && f7_alt) ? ALU_SUB : ALU_ADD;
          F3_SLL:  alu_operator_o = ALU_SLL;
          F3_SLT:  alu_operator_o = ALU_SLT;
          F3_SLTU: alu_operator_o = ALU_SLTU;
          F3_XOR:  alu_operator_o = ALU_XOR;
          F3_SR:   alu_operator_o = f7_alt ? ALU_SRA : ALU_SRL;
          F3_OR:   alu_operator_o = ALU_OR;
          default: alu_operator_o = ALU_AND;
        endcase
        // Register ops allow funct7 of zero, or ALT for SUB and SRA only
        if (opcode == OPC_OP) begin
          illegal = !(f7_zero || (f7_alt && (funct3 == F3_ADD || funct3 == F3_SR)));
        end else if (funct3 == F3_SLL) begin
          illegal = !f7_zero;
        end else if (funct3 == F3_SR) begin
          illegal = !(f7_zero || f7_alt);
        end
      end
      default: illegal = 1'b1;
    endcase

    // Illegal encodings take the single-cycle path with no side effects
    if (illegal) begin
      class_o  = CLS_ALU;
      we       = 1'b0;
      lsu_we_o = 1'b0;
    end
  end

  assign illegal_o = illegal;

  // Writes to x0 are dropped here
  assign rf_we_o = we & (rf_waddr_o != '0);

endmodule

//--- src/id_ctrl_pkg.sv
/*
 * Control encodings passed from the decoder to the operand mux,
 * the execute FSM and the EX/LSU interfaces
 */

package id_ctrl_pkg;

  // ALU operation, arithmetic and compare share one encoding space
  typedef enum logic [3:0] {
    ALU_ADD  = 4'd0,
    ALU_SUB  = 4'd1,
    ALU_XOR  = 4'd2,
    ALU_OR   = 4'd3,
    ALU_AND  = 4'd4,
    ALU_SLL  = 4'd5,
    ALU_SRL  = 4'd6,
    ALU_SRA  = 4'd7,
    ALU_SLT  = 4'd8,
    ALU_SLTU = 4'd9,
    // Branch comparisons
    ALU_EQ   = 4'd10,
    ALU_NE   = 4'd11,
    ALU_LT   = 4'd12,
    ALU_GE   = 4'd13,
    ALU_LTU  = 4'd14,
    ALU_GEU  = 4'd15
  } alu_op_e;

  // Operand A source
  typedef enum logic [1:0] {
    OP_A_REG  = 2'd0,
    OP_A_PC   = 2'd1,
    OP_A_ZERO = 2'd2
  } op_a_sel_e;

  // Operand B source
  typedef enum logic {
    OP_B_REG = 1'b0,
    OP_B_IMM = 1'b1
  } op_b_sel_e;

  // Immediate feeding operand B
  typedef enum logic [2:0] {
    IMM_I   = 3'd0,
    IMM_S   = 3'd1,
    IMM_B   = 3'd2,
    IMM_U   = 3'd3,
    IMM_J   = 3'd4,
    IMM_INC = 3'd5
  } imm_b_sel_e;

  // LSU access size
  typedef enum logic [1:0] {
    WORD = 2'b00,
    HALF = 2'b01,
    BYTE = 2'b10
  } lsu_type_e;

  // Execution path through the FSM
  typedef enum logic [1:0] {
    CLS_ALU    = 2'd0,
    CLS_MEM    = 2'd1,
    CLS_BRANCH = 2'd2,
    CLS_JUMP   = 2'd3
  } instr_class_e;

endpackage

//--- src/riscv_isa_pkg.sv
/*
 * RV32I ISA constants: data and register index widths, major opcodes,
 * instruction field positions, funct3/funct7 codes and the PC increment
 */

package riscv_isa_pkg;

  // Data, address and register index widths
  localparam int unsigned XLEN       = 32;
  localparam int unsigned REG_ADDR_W = 5;

  // Field positions and widths inside a 32-bit instruction
  localparam int unsigned RD_LSB   = 7;
  localparam int unsigned F3_LSB   = 12;
  localparam int unsigned RS1_LSB  = 15;
  localparam int unsigned RS2_LSB  = 20;
  localparam int unsigned F7_LSB   = 25;
  localparam int unsigned FUNCT3_W = 3;
  localparam int unsigned FUNCT7_W = 7;

  // Major opcodes handled by the decode stage
  typedef enum logic [6:0] {
    OPC_LUI    = 7'h37,
    OPC_AUIPC  = 7'h17,
    OPC_JAL    = 7'h6f,
    OPC_JALR   = 7'h67,
    OPC_BRANCH = 7'h63,
    OPC_LOAD   = 7'h03,
    OPC_STORE  = 7'h23,
    OPC_OP_IMM = 7'h13,
    OPC_OP     = 7'h33
  } opcode_e;

  // Branch conditions
  localparam logic [2:0] F3_BEQ  = 3'b000;
  localparam logic [2:0] F3_BNE  = 3'b001;
  localparam logic [2:0] F3_BLT  = 3'b100;
  localparam logic [2:0] F3_BGE  = 3'b101;
  localparam logic [2:0] F3_BLTU = 3'b110;
  localparam logic [2:0] F3_BGEU = 3'b111;

  // Load/store access sizes, bit 2 marks an unsigned load
  localparam logic [2:0] F3_B  = 3'b000;
  localparam logic [2:0] F3_H  = 3'b001;
  localparam logic [2:0] F3_W  = 3'b010;
  localparam logic [2:0] F3_BU = 3'b100;
  localparam logic [2:0] F3_HU = 3'b101;

  // Register/immediate ALU operations
  localparam logic [2:0] F3_ADD  = 3'b000;
  localparam logic [2:0] F3_SLL  = 3'b001;
  localparam logic [2:0] F3_SLT  = 3'b010;
  localparam logic [2:0] F3_SLTU = 3'b011;
  localparam logic [2:0] F3_XOR  = 3'b100;
  localparam logic [2:0] F3_SR   = 3'b101;
  localparam logic [2:0] F3_OR   = 3'b110;
  localparam logic [2:0] F3_AND  = 3'b111;

  // Alternate funct7, selects SUB and SRA
  localparam logic [6:0] F7_ALT = 7'b0100000;

  // Link address increment
  localparam logic [XLEN-1:0] INSN_INC = 32'd4;

endpackage
